//--- Makefile
SIM = obj_dir/Vqdr_cal_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module qdr_cal_tb -f qdr_cal_top.f

run: compile
	./$(SIM) > run.log 2>&1 || true
	cat run.log
	@if grep -q "SOME TESTS FAILED" run.log; then \
	  echo "simulation failed"; \
	  exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" run.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir run.log

//--- bench/qdr_cal_checker.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_cal_checker #(
  parameter int DATA_WIDTH = 8
) (
  input logic                  clk0,
  input logic                  reset,
  input qdr_cal_pkg::apb_req_t apb_req,
  input qdr_cal_pkg::apb_rsp_t apb_rsp,
  input logic                  qdr_w_n,
  input logic                  qdr_r_n,
  input logic [DATA_WIDTH-1:0] dly_rst,
  input logic [DATA_WIDTH-1:0] dly_en
);

  int fail_count = 0; // read by the testbench at the end of the run

  rw_exclusive: assert property (@(posedge clk0) disable iff (reset)
    qdr_w_n || qdr_r_n)
    else begin
      $error("qdr_w_n and qdr_r_n low in the same cycle");
      fail_count = fail_count + 1;
    end

  // a delay line is never reset and stepped in one cycle
  dly_exclusive: assert property (@(posedge clk0) disable iff (reset)
    (dly_en & dly_rst) == '0)
    else begin
      $error("dly_en and dly_rst set together on one bit");
      fail_count = fail_count + 1;
    end

  write_one_cycle: assert property (@(posedge clk0) disable iff (reset)
    $fell(qdr_w_n) |=> qdr_w_n)
    else begin
      $error("qdr_w_n held low for more than one cycle");
      fail_count = fail_count + 1;
    end

  no_wait_state: assert property (@(posedge clk0) disable iff (reset)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else begin
      $error("pready low in an access phase");
      fail_count = fail_count + 1;
    end

endmodule

`default_nettype wire

//--- bench/qdr_cal_tb.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_cal_tb;

  localparam int          DATA_WIDTH = 8;
  localparam int          TAP_WIDTH  = 5;
  localparam int          NUM_ROWS   = 3;
  localparam int          POLL_LIMIT = 1000; // status reads before giving up
  localparam logic [31:0] SEED       = 32'h87cf18f9;

  typedef logic [DATA_WIDTH-1:0][TAP_WIDTH-1:0] tap_vec_t;

  // one calibration scenario per row where lo above hi marks an empty window
  typedef struct packed {
    tap_vec_t              lo;
    tap_vec_t              hi;
    logic [DATA_WIDTH-1:0] swap;
    logic                  exp_fail;
  } cal_row_t;

  logic                  clk0 = 1'b0;
  logic                  reset;
  qdr_cal_pkg::apb_req_t apb_req;
  qdr_cal_pkg::apb_rsp_t apb_rsp;
  logic [DATA_WIDTH-1:0] qdr_q_rise;
  logic [DATA_WIDTH-1:0] qdr_q_fall;
  logic [DATA_WIDTH-1:0] qdr_q_rise_cal;
  logic [DATA_WIDTH-1:0] qdr_q_fall_cal;
  logic [DATA_WIDTH-1:0] qdr_d_rise;
  logic [DATA_WIDTH-1:0] qdr_d_fall;
  logic                  qdr_w_n;
  logic                  qdr_r_n;
  logic [DATA_WIDTH-1:0] dly_rst;
  logic [DATA_WIDTH-1:0] dly_en;
  logic [DATA_WIDTH-1:0] dly_inc_dec_n;

  cal_row_t              rows [NUM_ROWS];
  cal_row_t              row;
  tap_vec_t              taps     = '0; // delay line model
  logic [DATA_WIDTH-1:0] mem_rise = '0; // SRAM model contents
  logic [DATA_WIDTH-1:0] mem_fall = '0;
  logic [DATA_WIDTH-1:0] model_rise = '0;
  logic [DATA_WIDTH-1:0] model_fall = '0;
  logic [DATA_WIDTH-1:0] word_rise;
  logic [DATA_WIDTH-1:0] word_fall;
  logic                  model_on;

  always #20 clk0 = ~clk0;

  assign qdr_q_rise = model_on ? model_rise : word_rise;
  assign qdr_q_fall = model_on ? model_fall : word_fall;

  qdr_cal_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .TAP_WIDTH  (TAP_WIDTH)
  ) UUT (
    .clk0           (clk0),
    .reset          (reset),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp),
    .qdr_q_rise     (qdr_q_rise),
    .qdr_q_fall     (qdr_q_fall),
    .qdr_q_rise_cal (qdr_q_rise_cal),
    .qdr_q_fall_cal (qdr_q_fall_cal),
    .qdr_d_rise     (qdr_d_rise),
    .qdr_d_fall     (qdr_d_fall),
    .qdr_w_n        (qdr_w_n),
    .qdr_r_n        (qdr_r_n),
    .dly_rst        (dly_rst),
    .dly_en         (dly_en),
    .dly_inc_dec_n  (dly_inc_dec_n)
  );

  bind qdr_cal_top qdr_cal_checker #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_checker (
    .clk0    (clk0),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .qdr_w_n (qdr_w_n),
    .qdr_r_n (qdr_r_n),
    .dly_rst (dly_rst),
    .dly_en  (dly_en)
  );

  // delay lines step on the strobes and the SRAM answers only inside each window
  always @(negedge clk0) begin
    for (int i = 0; i < DATA_WIDTH; i++) begin
      if (dly_rst[i]) begin
        taps[i] = '0;
      end else if (dly_en[i]) begin
        taps[i] = dly_inc_dec_n[i] ? taps[i] + 1'b1 : taps[i] - 1'b1;
      end
    end
    if (!qdr_w_n) begin
      mem_rise = qdr_d_rise; // training write
      mem_fall = qdr_d_fall;
    end
    for (int i = 0; i < DATA_WIDTH; i++) begin
      if (!qdr_r_n && taps[i] >= row.lo[i] && taps[i] <= row.hi[i]) begin
        model_rise[i] = row.swap[i] ? mem_fall[i] : mem_rise[i]; // half cycle slip
        model_fall[i] = row.swap[i] ? mem_rise[i] : mem_fall[i];
      end else begin
        model_rise[i] = 1'b0;
        model_fall[i] = 1'b0;
      end
    end
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_status(input qdr_cal_pkg::cal_status_t got,
                              input qdr_cal_pkg::cal_status_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s fail/done/busy %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_taps(input tap_vec_t got, input tap_vec_t exp);
    for (int i = 0; i < DATA_WIDTH; i++) begin
      if (got[i] !== exp[i]) begin
        $display("ERR %0t: bit %0d parked at tap %0d, expected %0d", $time, i, got[i], exp[i]);
        abort_run();
      end
    end
  endtask

  task automatic check_word(input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // called right after a falling edge
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: data};
    @(negedge clk0);
    apb_req.penable = 1'b1;
    @(negedge clk0);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: '0};
    @(negedge clk0);
    apb_req.penable = 1'b1;
    @(negedge clk0);
    data    = apb_rsp.prdata;
    err     = apb_rsp.pslverr;
    apb_req = '0;
  endtask

  task automatic wait_done(output logic [31:0] data);
    logic err;
    int   polls;
    polls = 0;
    apb_read(qdr_cal_pkg::REG_STATUS, data, err);
    while (!data[1]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        $display("timeout while waiting for calibration to report done");
        abort_run();
      end
      apb_read(qdr_cal_pkg::REG_STATUS, data, err);
    end
  endtask

  // random words sent in slipped form must come out straightened
  task automatic check_correction(input logic [DATA_WIDTH-1:0] mask);
    logic [DATA_WIDTH-1:0] exp_rise;
    logic [DATA_WIDTH-1:0] exp_fall;
    model_on = 1'b0;
    for (int n = 0; n < 8; n++) begin
      exp_rise  = DATA_WIDTH'($urandom);
      exp_fall  = DATA_WIDTH'($urandom);
      word_rise = (exp_rise & ~mask) | (exp_fall & mask);
      word_fall = (exp_fall & ~mask) | (exp_rise & mask);
      @(negedge clk0);
      check_word(qdr_q_rise_cal, exp_rise, "qdr_q_rise_cal");
      check_word(qdr_q_fall_cal, exp_fall, "qdr_q_fall_cal");
    end
    model_on = 1'b1;
  endtask

  initial begin
    logic [31:0]              rdata;
    logic                     rerr;
    tap_vec_t                 exp_taps;
    logic [DATA_WIDTH-1:0]    exp_aligned;
    qdr_cal_pkg::cal_status_t exp_status;
    void'($urandom(SEED));
    reset     = 1'b1;
    apb_req   = '0;
    word_rise = '0;
    word_fall = '0;
    model_on  = 1'b0;
    rows[0] = '{lo: {5'd2, 5'd8, 5'd0, 5'd12, 5'd20, 5'd5, 5'd1, 5'd17},
                hi: {5'd9, 5'd15, 5'd6, 5'd19, 5'd31, 5'd11, 5'd4, 5'd26},
                swap: 8'ha5, exp_fail: 1'b0};
    rows[1] = '{lo: {5'd4, 5'd3, 5'd10, 5'd7, 5'd20, 5'd9, 5'd0, 5'd14}, // bit 3 empty
                hi: {5'd12, 5'd8, 5'd22, 5'd16, 5'd10, 5'd18, 5'd7, 5'd28},
                swap: 8'h42, exp_fail: 1'b1};
    rows[2] = '{lo: {5'd0, 5'd13, 5'd6, 5'd21, 5'd1, 5'd11, 5'd30, 5'd5},
                hi: {5'd31, 5'd13, 5'd27, 5'd24, 5'd3, 5'd20, 5'd31, 5'd16},
                swap: 8'h3c, exp_fail: 1'b0};
    row = '0;
    repeat (3) @(negedge clk0);
    reset = 1'b0;
    @(negedge clk0);
    check_bit(qdr_w_n, 1'b1, "qdr_w_n after reset");
    check_bit(qdr_r_n, 1'b1, "qdr_r_n after reset");
    check_word(dly_en, '0, "dly_en after reset");
    check_word(dly_rst, '0, "dly_rst after reset");
    apb_read(qdr_cal_pkg::REG_STATUS, rdata, rerr);
    check_status(rdata[2:0], '0, "STATUS after reset");
    check_bit(rerr, 1'b0, "pslverr for STATUS");
    apb_read(8'h0c, rdata, rerr);
    check_bit(rerr, 1'b1, "pslverr for offset 0xC");
    model_on = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = rows[r];
      apb_write(qdr_cal_pkg::REG_CTRL, 32'h1);
      apb_read(qdr_cal_pkg::REG_STATUS, rdata, rerr);
      check_status(rdata[2:0], '{fail: 1'b0, done: 1'b0, busy: 1'b1}, "STATUS after start");
      wait_done(rdata);
      exp_status = '{fail: row.exp_fail, done: 1'b1, busy: 1'b0};
      check_status(rdata[2:0], exp_status, "STATUS at the end of calibration");
      for (int i = 0; i < DATA_WIDTH; i++) begin
        if (row.exp_fail) begin
          exp_taps[i] = '0;
        end else begin
          exp_taps[i] = TAP_WIDTH'((int'(row.lo[i]) + int'(row.hi[i])) / 2); // window middle
        end
        exp_aligned[i] = row.swap[i] && (row.lo[i] <= row.hi[i]); // empty window never swaps
      end
      check_taps(taps, exp_taps);
      apb_read(qdr_cal_pkg::REG_ALIGNED, rdata, rerr);
      check_word(rdata[DATA_WIDTH-1:0], exp_aligned, "ALIGNED");
      check_bit(rerr, 1'b0, "pslverr for ALIGNED");
      if (!row.exp_fail) begin
        check_correction(row.swap);
      end
    end
    if (UUT.u_checker.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/qdr_bit_align.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_bit_align (
  input  logic                     clk0,
  input  logic                     reset,
  input  logic                     cal_start,
  output qdr_cal_pkg::cal_status_t status,
  output logic                     train_start,
  input  logic                     train_done,
  input  logic                     train_fail,
  output logic                     qdr_w_n,
  output logic                     qdr_r_n
);

  localparam int WAIT_W = $clog2(qdr_cal_pkg::READ_WAIT_CYCLES);

  qdr_cal_pkg::align_state_e state;
  logic [WAIT_W-1:0]         read_wait;
  logic [2:0]                finish_wait;

  always_ff @(posedge clk0) begin
    if (reset) begin
      state       <= qdr_cal_pkg::IDLE;
      status      <= '0;
      train_start <= 1'b0;
      qdr_w_n     <= 1'b1;
      qdr_r_n     <= 1'b1;
    end else begin
      train_start <= 1'b0;
      qdr_w_n     <= (state != qdr_cal_pkg::WRITE); // one write cycle just after WRITE
      qdr_r_n     <= !(state inside {qdr_cal_pkg::WAIT, qdr_cal_pkg::TRAIN,
                                     qdr_cal_pkg::FINISH}); // reads held open
      case (state)
        qdr_cal_pkg::IDLE, qdr_cal_pkg::DONE: begin
          if (cal_start) begin
            state       <= qdr_cal_pkg::WRITE;
            status.busy <= 1'b1;
            status.done <= 1'b0;
            status.fail <= 1'b0; // fresh run clears the old result
          end
        end
        qdr_cal_pkg::WRITE: begin
          read_wait <= WAIT_W'(qdr_cal_pkg::READ_WAIT_CYCLES - 1);
          state     <= qdr_cal_pkg::WAIT;
        end
        qdr_cal_pkg::WAIT: begin
          if (read_wait == '0) begin
            train_start <= 1'b1; // read data has settled
            state       <= qdr_cal_pkg::TRAIN;
          end else begin
            read_wait <= read_wait - 1'b1;
          end
        end
        qdr_cal_pkg::TRAIN: begin
          if (train_done) begin
            status.fail <= train_fail; // latched for software
            finish_wait <= '0;
            state       <= qdr_cal_pkg::FINISH;
          end
        end
        qdr_cal_pkg::FINISH: begin
          if (finish_wait == 3'd7) begin
            status.busy <= 1'b0;
            status.done <= 1'b1;
            state       <= qdr_cal_pkg::DONE;
          end else begin
            finish_wait <= finish_wait + 1'b1;
          end
        end
        default: begin
          state <= qdr_cal_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/qdr_bit_correct.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_bit_correct #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk0,
  input  logic                  reset,
  input  logic [DATA_WIDTH-1:0] aligned,
  input  logic [DATA_WIDTH-1:0] qdr_q_rise,
  input  logic [DATA_WIDTH-1:0] qdr_q_fall,
  output logic [DATA_WIDTH-1:0] qdr_q_rise_cal,
  output logic [DATA_WIDTH-1:0] qdr_q_fall_cal
);

  // bits that slipped half a cycle get rise and fall exchanged
  always_ff @(posedge clk0) begin
    if (reset) begin
      qdr_q_rise_cal <= '0;
      qdr_q_fall_cal <= '0;
    end else begin
      qdr_q_rise_cal <= (qdr_q_rise & ~aligned) | (qdr_q_fall & aligned);
      qdr_q_fall_cal <= (qdr_q_fall & ~aligned) | (qdr_q_rise & aligned);
    end
  end

endmodule

`default_nettype wire

//--- logic/qdr_bit_train.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_bit_train #(
  parameter int DATA_WIDTH = 8,
  parameter int TAP_WIDTH  = 5
) (
  input  logic                  clk0,
  input  logic                  reset,
  input  logic                  train_start,
  output logic                  train_done,
  output logic                  train_fail,
  input  logic [DATA_WIDTH-1:0] q_rise,
  input  logic [DATA_WIDTH-1:0] q_fall,
  output logic [DATA_WIDTH-1:0] dly_rst,
  output logic [DATA_WIDTH-1:0] dly_en,
  output logic [DATA_WIDTH-1:0] dly_inc_dec_n,
  output logic [DATA_WIDTH-1:0] aligned
);

  localparam int                   SETTLE   = qdr_cal_pkg::SETTLE_CYCLES;
  localparam int                   CNT_W    = $clog2(SETTLE) + 1;
  localparam logic [TAP_WIDTH-1:0] LAST_TAP = '1;

  typedef enum logic [2:0] {
    T_IDLE,
    T_SETTLE,
    T_SAMPLE,
    T_CENTRE_RST,
    T_CENTRE
  } train_state_e;

  train_state_e          state;
  logic [CNT_W-1:0]      settle_cnt;
  logic [TAP_WIDTH-1:0]  tap;
  logic [TAP_WIDTH-1:0]  step_cnt;
  logic                  phase;
  logic                  fail_r;
  logic [DATA_WIDTH-1:0] seen;
  logic [DATA_WIDTH-1:0] pass;
  logic [DATA_WIDTH-1:0] inc_need;
  logic [TAP_WIDTH:0]    run_len  [DATA_WIDTH];
  logic [TAP_WIDTH-1:0]  run_lo   [DATA_WIDTH];
  logic [TAP_WIDTH:0]    best_len [DATA_WIDTH];
  logic [TAP_WIDTH-1:0]  best_lo  [DATA_WIDTH];
  logic [TAP_WIDTH-1:0]  best_hi  [DATA_WIDTH];
  logic [TAP_WIDTH-1:0]  centre   [DATA_WIDTH];

  assign pass          = q_rise ^ q_fall; // pattern seen in either order
  assign dly_inc_dec_n = '1;              // taps only ever move up

  // centre tap per bit and which bits still need a step
  always_comb begin
    for (int i = 0; i < DATA_WIDTH; i++) begin
      centre[i]   = TAP_WIDTH'(({1'b0, best_lo[i]} + {1'b0, best_hi[i]}) >> 1);
      inc_need[i] = !fail_r && (step_cnt < centre[i]); // a failed run leaves taps at 0
    end
  end

  always_ff @(posedge clk0) begin
    if (reset) begin
      state      <= T_IDLE;
      dly_rst    <= '0;
      dly_en     <= '0;
      train_done <= 1'b0;
      train_fail <= 1'b0;
      aligned    <= '0;
      seen       <= '0;
      fail_r     <= 1'b0;
      tap        <= '0;
      settle_cnt <= '0;
      step_cnt   <= '0;
      phase      <= 1'b0;
    end else begin
      dly_rst    <= '0;
      dly_en     <= '0;
      train_done <= 1'b0;
      case (state)
        T_IDLE: begin
          if (train_start) begin
            dly_rst    <= '1; // sweep starts from tap 0
            seen       <= '0;
            aligned    <= '0;
            tap        <= '0;
            settle_cnt <= '0;
            state      <= T_SETTLE;
          end
        end
        T_SETTLE: begin
          if (settle_cnt == CNT_W'(SETTLE - 1)) begin
            state <= T_SAMPLE;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        T_SAMPLE: begin
          seen       <= seen | pass;
          aligned    <= aligned | (~seen & pass & ~q_rise); // first pass decides the swap
          settle_cnt <= '0;
          if (tap == LAST_TAP) begin
            state <= T_CENTRE_RST;
          end else begin
            dly_en <= '1;
            tap    <= tap + 1'b1;
            state  <= T_SETTLE;
          end
        end
        T_CENTRE_RST: begin
          dly_rst  <= '1;
          fail_r   <= ~&seen; // some bit never saw the pattern
          step_cnt <= '0;
          phase    <= 1'b0;
          state    <= T_CENTRE;
        end
        T_CENTRE: begin
          phase <= !phase; // one step every other cycle
          if (!phase) begin
            if (|inc_need) begin
              dly_en   <= inc_need;
              step_cnt <= step_cnt + 1'b1;
            end else begin
              train_done <= 1'b1;
              train_fail <= fail_r;
              state      <= T_IDLE;
            end
          end
        end
        default: begin
          state <= T_IDLE;
        end
      endcase
    end
  end

  // longest run of passing taps per bit
  always_ff @(posedge clk0) begin
    if (state == T_IDLE && train_start) begin
      for (int i = 0; i < DATA_WIDTH; i++) begin
        run_len[i]  <= '0;
        best_len[i] <= '0;
        best_lo[i]  <= '0;
        best_hi[i]  <= '0;
      end
    end else if (state == T_SAMPLE) begin
      for (int i = 0; i < DATA_WIDTH; i++) begin
        if (pass[i]) begin
          if (run_len[i] == '0) begin
            run_lo[i] <= tap; // new run opens here
          end
          run_len[i] <= run_len[i] + 1'b1;
          if (run_len[i] + 1'b1 > best_len[i]) begin
            best_len[i] <= run_len[i] + 1'b1;
            best_lo[i]  <= (run_len[i] == '0) ? tap : run_lo[i];
            best_hi[i]  <= tap;
          end
        end else begin
          run_len[i] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/qdr_cal_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_cal_apb_regs #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                     clk0,
  input  logic                     reset,
  input  qdr_cal_pkg::apb_req_t    apb_req,
  output qdr_cal_pkg::apb_rsp_t    apb_rsp,
  input  qdr_cal_pkg::cal_status_t status,
  input  logic [DATA_WIDTH-1:0]    aligned,
  output logic                     cal_start
);

  logic access;
  logic start_hit;

  assign access = apb_req.psel && apb_req.penable; // access phase of a transfer

  assign start_hit = access && apb_req.pwrite &&
                     (apb_req.paddr == qdr_cal_pkg::REG_CTRL) &&
                     apb_req.pwdata[0];

  // read mux and error decode for the access phase
  always_comb begin
    apb_rsp         = '0;
    apb_rsp.pready  = 1'b1; // never stalls
    case (apb_req.paddr)
      qdr_cal_pkg::REG_CTRL: begin
        apb_rsp.prdata = '0; // start bit is self clearing
      end
      qdr_cal_pkg::REG_STATUS: begin
        apb_rsp.prdata = 32'(status);
      end
      qdr_cal_pkg::REG_ALIGNED: begin
        apb_rsp.prdata = 32'(aligned);
      end
      default: begin
        apb_rsp.pslverr = access; // unknown offset
      end
    endcase
  end

  // one cycle start pulse after the CTRL write
  always_ff @(posedge clk0) begin
    if (reset) begin
      cal_start <= 1'b0;
    end else begin
      cal_start <= start_hit && !status.busy; // dropped while a run is active
    end
  end

endmodule

`default_nettype wire

//--- logic/qdr_cal_pkg.sv
`default_nettype none

package qdr_cal_pkg;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  localparam logic [7:0] REG_CTRL    = 8'h00; // bit 0 starts calibration
  localparam logic [7:0] REG_STATUS  = 8'h04; // busy, done, fail
  localparam logic [7:0] REG_ALIGNED = 8'h08; // per-bit swap mask

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WAIT,
    TRAIN,
    FINISH,
    DONE
  } align_state_e;

  // busy lands on bit 0 of STATUS
  typedef struct packed {
    logic fail;
    logic done;
    logic busy;
  } cal_status_t;

  localparam int READ_WAIT_CYCLES = 16; // settling time after the training write
  localparam int SETTLE_CYCLES    = 4;  // delay line settling per tap

endpackage

`default_nettype wire

//--- logic/qdr_cal_top.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_cal_top #(
  parameter int DATA_WIDTH = 8,
  parameter int TAP_WIDTH  = 5
) (
  input  logic                  clk0,
  input  logic                  reset,
  input  qdr_cal_pkg::apb_req_t apb_req,
  output qdr_cal_pkg::apb_rsp_t apb_rsp,
  input  logic [DATA_WIDTH-1:0] qdr_q_rise,
  input  logic [DATA_WIDTH-1:0] qdr_q_fall,
  output logic [DATA_WIDTH-1:0] qdr_q_rise_cal,
  output logic [DATA_WIDTH-1:0] qdr_q_fall_cal,
  output logic [DATA_WIDTH-1:0] qdr_d_rise,
  output logic [DATA_WIDTH-1:0] qdr_d_fall,
  output logic                  qdr_w_n,
  output logic                  qdr_r_n,
  output logic [DATA_WIDTH-1:0] dly_rst,
  output logic [DATA_WIDTH-1:0] dly_en,
  output logic [DATA_WIDTH-1:0] dly_inc_dec_n
);

  qdr_cal_pkg::cal_status_t status;
  logic                     cal_start;
  logic                     train_start;
  logic                     train_done;
  logic                     train_fail;
  logic [DATA_WIDTH-1:0]    aligned;

  assign qdr_d_rise = '1; // training pattern drives rise high
  assign qdr_d_fall = '0; // and fall low

  qdr_cal_apb_regs #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_regs (
    .clk0      (clk0),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .status    (status),
    .aligned   (aligned),
    .cal_start (cal_start)
  );

  qdr_bit_align u_align (
    .clk0        (clk0),
    .reset       (reset),
    .cal_start   (cal_start),
    .status      (status),
    .train_start (train_start),
    .train_done  (train_done),
    .train_fail  (train_fail),
    .qdr_w_n     (qdr_w_n),
    .qdr_r_n     (qdr_r_n)
  );

  qdr_bit_train #(
    .DATA_WIDTH (DATA_WIDTH),
    .TAP_WIDTH  (TAP_WIDTH)
  ) u_train (
    .clk0          (clk0),
    .reset         (reset),
    .train_start   (train_start),
    .train_done    (train_done),
    .train_fail    (train_fail),
    .q_rise        (qdr_q_rise),
    .q_fall        (qdr_q_fall),
    .dly_rst       (dly_rst),
    .dly_en        (dly_en),
    .dly_inc_dec_n (dly_inc_dec_n),
    .aligned       (aligned)
  );

  qdr_bit_correct #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_correct (
    .clk0           (clk0),
    .reset          (reset),
    .aligned        (aligned),
    .qdr_q_rise     (qdr_q_rise),
    .qdr_q_fall     (qdr_q_fall),
    .qdr_q_rise_cal (qdr_q_rise_cal),
    .qdr_q_fall_cal (qdr_q_fall_cal)
  );

endmodule

`default_nettype wire

//--- qdr_cal_top.f
logic/qdr_cal_pkg.sv
logic/qdr_cal_apb_regs.sv
logic/qdr_bit_align.sv
logic/qdr_bit_train.sv
logic/qdr_bit_correct.sv
logic/qdr_cal_top.sv
bench/qdr_cal_checker.sv
bench/qdr_cal_tb.sv
